//--- filelist.f
+incdir+logic
logic/uclk_pkg.sv
logic/uclk_mmio_slave.sv
logic/uclk_csr.sv
logic/uclk_tick_gen.sv
logic/uclk_freq_counter.sv
logic/uclk_top.sv
sim/uclk_tb_sva.sv
sim/uclk_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module uclk_tb \
   -Mdir obj_dir -o uclk_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed"
   exit 1
fi

./obj_dir/uclk_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^sim passed$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sim/uclk_tb.sv
`timescale 1ns/1ps

`include "uclk_consts.svh"

module uclk_tb;

   localparam int CLK_PERIOD    = 100;
   localparam int RST_CYCLES    = 8;
   localparam int DRIVE_DELAY   = 1;
   // Two 140-cycle settles plus about 140 cycles of bus traffic and tick sampling
   localparam int MAX_CYCLES    = 3000;
   localparam int SETTLE_CYCLES = 140;
   localparam int RD_LIMIT      = 10;

   localparam logic [`UCLK_ADDR_W-1:0] ADDR_DFH  = 12'h000;
   localparam logic [`UCLK_ADDR_W-1:0] ADDR_CMD0 = 12'h008;
   localparam logic [`UCLK_ADDR_W-1:0] ADDR_CMD1 = 12'h010;
   localparam logic [`UCLK_ADDR_W-1:0] ADDR_STS0 = 12'h018;
   localparam logic [`UCLK_ADDR_W-1:0] ADDR_STS1 = 12'h020;
   localparam logic [`UCLK_ADDR_W-1:0] ADDR_HOLE = 12'h100;

   logic                    clk;
   logic                    rst_n;
   logic                    host_write;
   logic                    host_read;
   logic                    host_32b;
   logic [`UCLK_ADDR_W-1:0] host_addr;
   logic [`UCLK_DATA_W-1:0] host_wdata;
   logic [`UCLK_DATA_W-1:0] host_rdata;
   logic                    host_rvalid;
   logic                    tick_0;
   logic                    tick_1;

   // Expected register contents, one per 8-byte slot
   logic [`UCLK_DATA_W-1:0] model [`UCLK_NUM_REG];
   int                      seed;
   int                      cycle_count;

   uclk_top u_uclk_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .host_write  (host_write),
      .host_read   (host_read),
      .host_32b    (host_32b),
      .host_addr   (host_addr),
      .host_wdata  (host_wdata),
      .host_rdata  (host_rdata),
      .host_rvalid (host_rvalid),
      .tick_0      (tick_0),
      .tick_1      (tick_1)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   // --------------------
   // Run guards
   // --------------------
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

   // Bound checker failures end the run at once
   always @(negedge clk) begin
      if (u_uclk_top.u_sva.fail_count != 0) begin
         $display("sim failed");
         $fatal(1, "concurrent assertion failed");
      end
   end

   // --------------------
   // Helpers
   // --------------------
   function automatic logic [`UCLK_DATA_W-1:0] random_word();
      return {$random(seed), $random(seed)};
   endfunction

   // Valid flag plus count in the low word
   function automatic logic [`UCLK_DATA_W-1:0] status_word(input int count);
      return {1'b1, 31'b0, 32'(count)};
   endfunction

   // Pulse train of one channel
   function automatic logic tick_of(input int channel);
      return (channel == 0) ? tick_0 : tick_1;
   endfunction

   // Read value from the register map rules
   function automatic logic [`UCLK_DATA_W-1:0] predict_read(
      input logic [`UCLK_ADDR_W-1:0] addr,
      input logic                    is32
   );
      logic [`UCLK_DATA_W-1:0] word;
      int                      idx;
      idx  = int'(addr[`UCLK_ADDR_W-1:3]);
      word = (idx < `UCLK_NUM_REG) ? model[idx] : '0;
      // Chosen half in place
      if (is32) begin
         word = addr[2] ? {word[63:32], 32'h0} : {32'h0, word[31:0]};
      end
      return word;
   endfunction

   task automatic expect_equal(
      input logic [`UCLK_DATA_W-1:0] got,
      input logic [`UCLK_DATA_W-1:0] exp,
      input string                   what
   );
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
         $display("sim failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // One-cycle write strobe, model follows the commands only
   task automatic write_reg(
      input logic [`UCLK_ADDR_W-1:0] addr,
      input logic [`UCLK_DATA_W-1:0] data,
      input logic                    is32
   );
      int idx;
      idx = int'(addr[`UCLK_ADDR_W-1:3]);
      @(posedge clk);
      #DRIVE_DELAY;
      host_write = 1'b1;
      host_addr  = addr;
      host_wdata = data;
      host_32b   = is32;
      @(posedge clk);
      #DRIVE_DELAY;
      host_write = 1'b0;
      host_32b   = 1'b0;
      if (idx == 1 || idx == 2) begin
         if (!is32) begin
            model[idx] = data;
         end else if (addr[2]) begin
            model[idx][63:32] = data[63:32];
         end else begin
            model[idx][31:0] = data[31:0];
         end
      end
   endtask

   task automatic read_check(
      input logic [`UCLK_ADDR_W-1:0] addr,
      input logic                    is32,
      input string                   what
   );
      logic [`UCLK_DATA_W-1:0] exp;
      int                      waited;
      exp = predict_read(addr, is32);
      @(posedge clk);
      #DRIVE_DELAY;
      host_read = 1'b1;
      host_addr = addr;
      host_32b  = is32;
      @(posedge clk);
      #DRIVE_DELAY;
      host_read = 1'b0;
      host_32b  = 1'b0;
      waited    = 0;
      // Response sampled mid-cycle
      @(negedge clk);
      while (!host_rvalid) begin
         waited = waited + 1;
         if (waited > RD_LIMIT) begin
            $display("No read response for %s within %0d cycles", what, RD_LIMIT);
            $display("sim failed");
            $fatal(1, "read timeout");
         end
         @(negedge clk);
      end
      expect_equal(host_rdata, exp, what);
   endtask

   // Cycles between two pulses of one channel
   task automatic measure_tick_period(input int channel, input int period);
      int gap;
      @(negedge clk);
      while (!tick_of(channel)) @(negedge clk);
      gap = 0;
      do begin
         @(negedge clk);
         gap = gap + 1;
      end while (!tick_of(channel));
      expect_equal(64'(gap), 64'(period), $sformatf("tick_%0d period", channel));
   endtask

   // --------------------
   // Directed sequence
   // --------------------
   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      host_write  = 1'b0;
      host_read   = 1'b0;
      host_32b    = 1'b0;
      host_addr   = '0;
      host_wdata  = '0;
      seed        = 32'hd255;
      cycle_count = 0;
      model[0]    = `UCLK_DFH;
      for (int i = 1; i < `UCLK_NUM_REG; i++) model[i] = '0;

      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;

      // Reset values, all inside the first window
      read_check(ADDR_DFH, 1'b0, "header after reset");
      read_check(ADDR_CMD0, 1'b0, "command 0 after reset");
      read_check(ADDR_CMD1, 1'b0, "command 1 after reset");
      read_check(ADDR_STS0, 1'b0, "status 0 after reset");
      read_check(ADDR_STS1, 1'b0, "status 1 after reset");

      // Read-only slots ignore writes
      write_reg(ADDR_DFH, random_word(), 1'b0);
      write_reg(ADDR_STS0, random_word(), 1'b0);
      write_reg(ADDR_STS1, random_word(), 1'b0);
      read_check(ADDR_DFH, 1'b0, "header after write");
      read_check(ADDR_STS0, 1'b0, "status 0 after write");
      read_check(ADDR_STS1, 1'b0, "status 1 after write");

      // Full-width command writes
      write_reg(ADDR_CMD0, random_word(), 1'b0);
      read_check(ADDR_CMD0, 1'b0, "command 0 random write");
      write_reg(ADDR_CMD1, random_word(), 1'b0);
      read_check(ADDR_CMD1, 1'b0, "command 1 random write");

      // Lane writes, other half left alone
      write_reg(ADDR_CMD0 | 12'h4, random_word(), 1'b1);
      read_check(ADDR_CMD0, 1'b0, "command 0 upper lane write");
      write_reg(ADDR_CMD1, random_word(), 1'b1);
      read_check(ADDR_CMD1, 1'b0, "command 1 lower lane write");

      // Half reads
      read_check(ADDR_CMD0, 1'b1, "command 0 lower half");
      read_check(ADDR_CMD0 | 12'h4, 1'b1, "command 0 upper half");
      read_check(ADDR_CMD1, 1'b1, "command 1 lower half");
      read_check(ADDR_CMD1 | 12'h4, 1'b1, "command 1 upper half");
      read_check(ADDR_DFH, 1'b1, "header lower half");
      read_check(ADDR_DFH | 12'h4, 1'b1, "header upper half");

      // Past the map
      read_check(ADDR_HOLE, 1'b0, "unmapped address");

      // Both channels running, N=4 and N=8
      write_reg(ADDR_CMD0, {1'b1, 47'b0, 16'd4}, 1'b0);
      write_reg(ADDR_CMD1, {1'b1, 47'b0, 16'd8}, 1'b0);
      repeat (SETTLE_CYCLES) @(posedge clk);
      model[3] = status_word(64 / 4);
      model[4] = status_word(64 / 8);
      read_check(ADDR_STS0, 1'b0, "status 0 with N=4");
      read_check(ADDR_STS1, 1'b0, "status 1 with N=8");
      measure_tick_period(0, 4);
      measure_tick_period(1, 8);

      // Channel 0 off, channel 1 keeps running
      write_reg(ADDR_CMD0, {1'b0, 47'b0, 16'd4}, 1'b0);
      repeat (SETTLE_CYCLES) @(posedge clk);
      model[3] = status_word(0);
      read_check(ADDR_CMD0, 1'b0, "command 0 disabled");
      read_check(ADDR_STS0, 1'b0, "status 0 after disable");
      read_check(ADDR_STS1, 1'b0, "status 1 after channel 0 disable");

      repeat (4) @(posedge clk);
      if (u_uclk_top.u_sva.fail_count == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("sim failed");
         $fatal(1, "concurrent assertion failed");
      end
   end

endmodule

//--- sim/uclk_tb_sva.sv
`timescale 1ns/1ps

`include "uclk_consts.svh"

module uclk_tb_sva (
   input logic                    clk,
   input logic                    rst_n,
   input logic                    host_read,
   input logic                    host_rvalid,
   input logic                    tick_0,
   input logic                    tick_1,
   input logic [`UCLK_DATA_W-1:0] freq_cmd_0,
   input logic [`UCLK_DATA_W-1:0] freq_cmd_1
);

   // Failures so far, polled by the testbench
   int unsigned fail_count = 0;
   // Edges seen with reset low
   int unsigned rst_cycles = 0;
   logic        cmds_idle;

   assign cmds_idle = (freq_cmd_0 == '0) && (freq_cmd_1 == '0);

   always @(posedge clk) begin
      if (!rst_n) begin
         rst_cycles <= rst_cycles + 1;
      end else begin
         rst_cycles <= 0;
      end
   end

   // --------------------
   // Read timing
   // --------------------
   // Answer exactly three cycles after the strobe, never otherwise
   rvalid_timing: assert property (@(posedge clk) disable iff (!rst_n)
      host_rvalid == $past(host_read, 3))
   else begin
      fail_count = fail_count + 1;
      $error("host_rvalid not exactly 3 cycles after host_read");
   end

   // --------------------
   // Quiet outputs
   // --------------------
   // Outputs settle one edge into reset
   quiet_in_reset: assert property (@(posedge clk)
      (!rst_n && rst_cycles > 0) |-> (!host_rvalid && !tick_0 && !tick_1))
   else begin
      fail_count = fail_count + 1;
      $error("host_rvalid or a tick high during reset");
   end

   // Tick is registered, so both commands must be zero for two samples
   no_tick_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (cmds_idle && $past(cmds_idle)) |-> (!tick_0 && !tick_1))
   else begin
      fail_count = fail_count + 1;
      $error("tick while both commands are zero");
   end

endmodule

bind uclk_top uclk_tb_sva u_sva (
   .clk         (clk),
   .rst_n       (rst_n),
   .host_read   (host_read),
   .host_rvalid (host_rvalid),
   .tick_0      (tick_0),
   .tick_1      (tick_1),
   .freq_cmd_0  (freq_cmd_0),
   .freq_cmd_1  (freq_cmd_1)
);

//--- logic/uclk_top.sv
`timescale 1ns/1ps

`include "uclk_consts.svh"

module uclk_top import uclk_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,

   // Host register port
   input  logic                    host_write,
   input  logic                    host_read,
   input  logic                    host_32b,
   input  logic [`UCLK_ADDR_W-1:0] host_addr,
   input  logic [`UCLK_DATA_W-1:0] host_wdata,
   output logic [`UCLK_DATA_W-1:0] host_rdata,
   output logic                    host_rvalid,

   // Generated pulse trains
   output logic                    tick_0,
   output logic                    tick_1
);

   logic                    csr_write;
   logic                    csr_read;
   logic                    csr_read_32b;
   logic [`UCLK_ADDR_W-1:0] csr_waddr;
   logic [`UCLK_ADDR_W-1:0] csr_raddr;
   logic [`UCLK_DATA_W-1:0] csr_wdata;
   csr_access_type_t        csr_write_type;

   logic [`UCLK_DATA_W-1:0] freq_cmd_0;
   logic [`UCLK_DATA_W-1:0] freq_cmd_1;
   logic [`UCLK_DATA_W-1:0] freq_sts_0;
   logic [`UCLK_DATA_W-1:0] freq_sts_1;

   // --------------------
   // Host side
   // --------------------
   uclk_mmio_slave u_mmio (
      .clk            (clk),
      .rst_n          (rst_n),
      .host_write     (host_write),
      .host_read      (host_read),
      .host_32b       (host_32b),
      .host_addr      (host_addr),
      .host_wdata     (host_wdata),
      .csr_write      (csr_write),
      .csr_read       (csr_read),
      .csr_read_32b   (csr_read_32b),
      .csr_waddr      (csr_waddr),
      .csr_raddr      (csr_raddr),
      .csr_wdata      (csr_wdata),
      .csr_write_type (csr_write_type)
   );

   uclk_csr u_csr (
      .clk                (clk),
      .rst_n              (rst_n),
      .csr_write          (csr_write),
      .csr_read           (csr_read),
      .csr_read_32b       (csr_read_32b),
      .csr_waddr          (csr_waddr),
      .csr_raddr          (csr_raddr),
      .csr_wdata          (csr_wdata),
      .csr_write_type     (csr_write_type),
      .csr_readdata       (host_rdata),
      .csr_readdata_valid (host_rvalid),
      .freq_sts_0         (freq_sts_0),
      .freq_sts_1         (freq_sts_1),
      .freq_cmd_0         (freq_cmd_0),
      .freq_cmd_1         (freq_cmd_1)
   );

   // --------------------
   // Channels
   // --------------------
   uclk_tick_gen u_tick_0 (.clk(clk), .rst_n(rst_n), .freq_cmd(freq_cmd_0), .tick(tick_0));
   uclk_tick_gen u_tick_1 (.clk(clk), .rst_n(rst_n), .freq_cmd(freq_cmd_1), .tick(tick_1));

   uclk_freq_counter u_cnt_0 (.clk(clk), .rst_n(rst_n), .tick(tick_0), .freq_sts(freq_sts_0));
   uclk_freq_counter u_cnt_1 (.clk(clk), .rst_n(rst_n), .tick(tick_1), .freq_sts(freq_sts_1));

endmodule

//--- logic/uclk_freq_counter.sv
`timescale 1ns/1ps

`include "uclk_consts.svh"

module uclk_freq_counter (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    tick,
   output logic [`UCLK_DATA_W-1:0] freq_sts
);

   localparam int WIN_W  = $clog2(`UCLK_WINDOW);
   localparam int CNT_W  = 32;
   localparam int PAD_W  = `UCLK_DATA_W - CNT_W - 1;

   logic [WIN_W-1:0] win_cnt;
   logic [CNT_W-1:0] edge_cnt;
   logic             win_end;

   // Last cycle of the window
   assign win_end = (win_cnt == WIN_W'(`UCLK_WINDOW - 1));

   // --------------------
   // Window and tick count
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_cnt  <= '0;
         edge_cnt <= '0;
      end else begin
         win_cnt <= win_end ? '0 : win_cnt + 1'b1;
         if (win_end) begin
            // Boundary tick belongs to the new window
            edge_cnt <= CNT_W'(tick);
         end else if (tick) begin
            edge_cnt <= edge_cnt + 1'b1;
         end
      end
   end

   // --------------------
   // Status latch
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         freq_sts <= '0;
      end else if (win_end) begin
         // Valid flag stays set after the first window
         freq_sts <= {1'b1, {PAD_W{1'b0}}, edge_cnt};
      end
   end

endmodule

//--- logic/uclk_tick_gen.sv
`timescale 1ns/1ps

`include "uclk_consts.svh"

module uclk_tick_gen (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`UCLK_DATA_W-1:0] freq_cmd,
   output logic                    tick
);

   logic [`UCLK_DIV_W-1:0]  div;
   logic                    active;
   logic                    cmd_changed;
   logic [`UCLK_DATA_W-1:0] cmd_q;
   logic [`UCLK_DIV_W-1:0]  cnt;

   // Enable in bit 63, divisor in the low field
   assign div         = freq_cmd[`UCLK_DIV_W-1:0];
   assign active      = freq_cmd[`UCLK_DATA_W-1] && (div != '0);
   assign cmd_changed = (freq_cmd != cmd_q);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cmd_q <= '0;
         cnt   <= '0;
         tick  <= 1'b0;
      end else begin
         cmd_q <= freq_cmd;
         if (!active || cmd_changed) begin
            // Idle, or restart phase on a new command
            cnt  <= div - 1'b1;
            tick <= 1'b0;
         end else if (cnt == '0) begin
            // One pulse every div cycles
            cnt  <= div - 1'b1;
            tick <= 1'b1;
         end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
         end
      end
   end

endmodule

//--- logic/uclk_csr.sv
`timescale 1ns/1ps

`include "uclk_consts.svh"

module uclk_csr import uclk_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,

   // Request from the slave
   input  logic                    csr_write,
   input  logic                    csr_read,
   input  logic                    csr_read_32b,
   input  logic [`UCLK_ADDR_W-1:0] csr_waddr,
   input  logic [`UCLK_ADDR_W-1:0] csr_raddr,
   input  logic [`UCLK_DATA_W-1:0] csr_wdata,
   input  csr_access_type_t        csr_write_type,

   // Read response
   output logic [`UCLK_DATA_W-1:0] csr_readdata,
   output logic                    csr_readdata_valid,

   // Channel side
   input  logic [`UCLK_DATA_W-1:0] freq_sts_0,
   input  logic [`UCLK_DATA_W-1:0] freq_sts_1,
   output logic [`UCLK_DATA_W-1:0] freq_cmd_0,
   output logic [`UCLK_DATA_W-1:0] freq_cmd_1
);

   // --------------------
   // Register map
   // --------------------
   localparam int NUM_REG = `UCLK_NUM_REG;
   localparam int IDX_W   = $clog2(NUM_REG);
   localparam int HALF_W  = `UCLK_DATA_W/2;

   // Slot numbers, 8 bytes apart
   localparam int ID_DFH  = 0;
   localparam int ID_CMD0 = 1;
   localparam int ID_CMD1 = 2;
   localparam int ID_STS0 = 3;
   localparam int ID_STS1 = 4;

   // Only the commands are host-writable
   localparam logic [NUM_REG-1:0] REG_RW = 5'b00110;

   localparam logic [`UCLK_DATA_W-1:0] REG_RST [NUM_REG] = '{
      `UCLK_DFH, 64'h0, 64'h0, 64'h0, 64'h0
   };

   logic [`UCLK_DATA_W-1:0]            csr_reg  [NUM_REG];
   logic [`UCLK_DATA_W-1:0]            reg_hw   [NUM_REG];
   csr_bit_attr_t [`UCLK_DATA_W-1:0]   reg_attr [NUM_REG];
   uclk_hw_state_t                     hw_state;

   logic                    csr_read_reg;
   logic                    csr_read_32b_reg;
   logic [`UCLK_ADDR_W-1:0] csr_raddr_reg;
   logic                    range_valid;
   logic [IDX_W-1:0]        rd_idx;

   // --------------------
   // Register update
   // --------------------
   assign hw_state.reset_n    = rst_n;
   assign hw_state.wr_data    = csr_wdata;
   assign hw_state.write_type = csr_write_type;

   // Values that read-only bits follow
   assign reg_hw[ID_DFH]  = `UCLK_DFH;
   assign reg_hw[ID_CMD0] = '0;
   assign reg_hw[ID_CMD1] = '0;
   assign reg_hw[ID_STS0] = freq_sts_0;
   assign reg_hw[ID_STS1] = freq_sts_1;

   // Whole register takes one attribute
   always_comb begin
      for (int r = 0; r < NUM_REG; r++) begin
         for (int b = 0; b < `UCLK_DATA_W; b++) begin
            reg_attr[r][b] = REG_RW[r] ? RW : RO;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int r = 0; r < NUM_REG; r++) begin
         // Full slot compare, no aliasing above the map
         csr_reg[r] <= uclk_update_reg(
            reg_attr[r],
            REG_RST[r],
            reg_hw[r],
            csr_reg[r],
            csr_write && (csr_waddr[`UCLK_ADDR_W-1:3] == r),
            hw_state
         );
      end
   end

   assign freq_cmd_0 = csr_reg[ID_CMD0];
   assign freq_cmd_1 = csr_reg[ID_CMD1];

   // --------------------
   // Read pipeline
   // --------------------

   // Stage 1 holds the request
   always_ff @(posedge clk) begin
      csr_raddr_reg    <= csr_raddr;
      csr_read_32b_reg <= csr_read_32b;
      if (!rst_n) begin
         csr_read_reg <= 1'b0;
      end else begin
         csr_read_reg <= csr_read;
      end
   end

   // Range check alongside stage 1
   always_ff @(posedge clk) begin
      range_valid <= (csr_raddr[`UCLK_ADDR_W-1:3] < NUM_REG);
   end

   assign rd_idx = csr_raddr_reg[IDX_W+2:3];

   // Stage 2 returns data, zero past the map
   always_ff @(posedge clk) begin
      csr_readdata <= '0;
      if (csr_read_reg && range_valid) begin
         if (!csr_read_32b_reg) begin
            csr_readdata <= csr_reg[rd_idx];
         end else if (csr_raddr_reg[2]) begin
            csr_readdata[`UCLK_DATA_W-1:HALF_W] <= csr_reg[rd_idx][`UCLK_DATA_W-1:HALF_W];
         end else begin
            csr_readdata[HALF_W-1:0] <= csr_reg[rd_idx][HALF_W-1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_readdata_valid <= 1'b0;
      end else begin
         csr_readdata_valid <= csr_read_reg;
      end
   end

endmodule

//--- logic/uclk_mmio_slave.sv
`timescale 1ns/1ps

`include "uclk_consts.svh"

module uclk_mmio_slave import uclk_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,

   // Host strobes
   input  logic                    host_write,
   input  logic                    host_read,
   input  logic                    host_32b,
   input  logic [`UCLK_ADDR_W-1:0] host_addr,
   input  logic [`UCLK_DATA_W-1:0] host_wdata,

   // Request toward the register file
   output logic                    csr_write,
   output logic                    csr_read,
   output logic                    csr_read_32b,
   output logic [`UCLK_ADDR_W-1:0] csr_waddr,
   output logic [`UCLK_ADDR_W-1:0] csr_raddr,
   output logic [`UCLK_DATA_W-1:0] csr_wdata,
   output csr_access_type_t        csr_write_type
);

   // --------------------
   // Strobes
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_write <= 1'b0;
         csr_read  <= 1'b0;
      end else begin
         csr_write <= host_write;
         csr_read  <= host_read;
      end
   end

   // --------------------
   // Write and read payload
   // --------------------
   always_ff @(posedge clk) begin
      // Write side held until the next write
      if (host_write) begin
         csr_waddr <= host_addr;
         csr_wdata <= host_wdata;
         // Address bit 2 picks the lane
         if (!host_32b) begin
            csr_write_type <= FULL64;
         end else if (host_addr[2]) begin
            csr_write_type <= UPPER32;
         end else begin
            csr_write_type <= LOWER32;
         end
      end
      // Read side
      if (host_read) begin
         csr_raddr    <= host_addr;
         csr_read_32b <= host_32b;
      end
   end

endmodule

//--- logic/uclk_pkg.sv
package uclk_pkg;

`include "uclk_consts.svh"

   // --------------------
   // Register access types
   // --------------------

   // Width and lane of a host write
   typedef enum logic [1:0] {
      FULL64  = 2'b00,
      LOWER32 = 2'b01,
      UPPER32 = 2'b10
   } csr_access_type_t;

   // Per-bit register attribute
   typedef enum logic {
      RO = 1'b0,
      RW = 1'b1
   } csr_bit_attr_t;

   // State seen by every register on each update
   typedef struct packed {
      logic                    reset_n;
      logic [`UCLK_DATA_W-1:0] wr_data;
      csr_access_type_t        write_type;
   } uclk_hw_state_t;

   // Next value of one register, bit by bit
   function automatic logic [`UCLK_DATA_W-1:0] uclk_update_reg(
      input csr_bit_attr_t [`UCLK_DATA_W-1:0] attr,
      input logic [`UCLK_DATA_W-1:0]          reset_val,
      input logic [`UCLK_DATA_W-1:0]          hw_val,
      input logic [`UCLK_DATA_W-1:0]          cur_val,
      input logic                             write_hit,
      input uclk_hw_state_t                   state
   );
      logic [`UCLK_DATA_W-1:0] nxt;
      logic                    lane_en;
      for (int i = 0; i < `UCLK_DATA_W; i++) begin
         // Lane select for 32-bit writes
         case (state.write_type)
            LOWER32: lane_en = (i < `UCLK_DATA_W/2);
            UPPER32: lane_en = (i >= `UCLK_DATA_W/2);
            default: lane_en = 1'b1;
         endcase
         if (!state.reset_n) begin
            nxt[i] = reset_val[i];
         end else if (attr[i] == RW) begin
            // Write data already sits in its lane
            nxt[i] = (write_hit && lane_en) ? state.wr_data[i] : cur_val[i];
         end else begin
            // Read-only bits track hardware
            nxt[i] = hw_val[i];
         end
      end
      return nxt;
   endfunction

endpackage

//--- logic/uclk_consts.svh
`ifndef UCLK_CONSTS_SVH
`define UCLK_CONSTS_SVH

// --------------------
// Bus widths
// --------------------

// Host data word
`define UCLK_DATA_W 64
// Byte address, 4 KB space
`define UCLK_ADDR_W 12

// --------------------
// Register map
// --------------------

// Header, two commands, two status words
`define UCLK_NUM_REG 5
// Feature header value
`define UCLK_DFH 64'h3000010000000014

// --------------------
// Clock channels
// --------------------

// Cycles per measurement window
`define UCLK_WINDOW 64
// Divisor field in a command word
`define UCLK_DIV_W 16

`endif
